// File: dcache_cfg_pkg.sv
package dcache_cfg_pkg;

    localparam int ADDR_W = 32;
    localparam int LINE_BYTES = 16;
    localparam int OFFSET_W = $clog2(LINE_BYTES);
    localparam int WORDS_PER_LINE = LINE_BYTES / 4;
    localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE);
    localparam int SETS = 32;
    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NR_WAYS = 2;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;

    // set index above word position
    typedef logic [INDEX_W+WORD_IDX_W-1:0] ram_addr_t;

endpackage

// File: axi_cfg_pkg.sv
package axi_cfg_pkg;

    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;

    // 4-byte beats
    localparam axi_size_t AXI_SIZE_WORD = 3'd2;

    // one line per burst, len is beats less one
    localparam axi_len_t AXI_LEN_LINE = axi_len_t'(dcache_cfg_pkg::WORDS_PER_LINE - 1);

endpackage

// File: dcache_ram.sv
module dcache_ram #(
    parameter type entry_t = logic [31:0],
    parameter int DEPTH = 32
) (
    input  logic clk,
    input  logic we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  entry_t wdata,
    // byte lanes for whole-byte entries, else one enable
    input  logic [(($bits(entry_t) % 8 == 0) ? $bits(entry_t) / 8 : 1)-1:0] wbe,
    output entry_t rdata
);

    localparam int W = $bits(entry_t);
    localparam int BE_W = $bits(wbe);
    localparam int LANE_W = W / BE_W;

    logic [W-1:0] mem [DEPTH];
    logic [W-1:0] wbits;

    assign wbits = wdata;

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < BE_W; b++) begin
                if (wbe[b]) begin
                    mem[waddr][b*LANE_W +: LANE_W] <= wbits[b*LANE_W +: LANE_W];
                end
            end
        end
        // old contents on a same-address write
        rdata <= mem[raddr];
    end

    assert property (@(posedge clk) !$isunknown(we))
        else $error("dcache_ram: write enable is unknown");

endmodule

// File: dcache_meta.sv
module dcache_meta (
    input  logic clk,
    input  logic rst,
    input  dcache_cfg_pkg::index_t lookup_index,
    input  dcache_cfg_pkg::tag_t lookup_tag,
    input  dcache_cfg_pkg::tag_t way_tag0,
    input  dcache_cfg_pkg::tag_t way_tag1,
    input  logic touch,
    input  logic set_dirty,
    input  logic fill,
    input  logic clear_dirty,
    input  logic upd_way,
    output logic hit,
    output logic hit_way,
    output logic victim_way,
    output logic victim_dirty,
    output dcache_cfg_pkg::tag_t victim_tag
);
    import dcache_cfg_pkg::*;

    logic [NR_WAYS-1:0] valid [SETS];
    logic [NR_WAYS-1:0] dirty [SETS];
    logic [NR_WAYS-1:0] lru [SETS];

    // set state, aligned with the tag ram read
    logic [NR_WAYS-1:0] valid_q;
    logic [NR_WAYS-1:0] dirty_q;
    logic [NR_WAYS-1:0] lru_q;
    logic [NR_WAYS-1:0] way_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '{default: '0};
            dirty <= '{default: '0};
            lru <= '{default: '0};
            valid_q <= '0;
            dirty_q <= '0;
            lru_q <= '0;
        end else begin
            valid_q <= valid[lookup_index];
            dirty_q <= dirty[lookup_index];
            lru_q <= lru[lookup_index];
            if (fill) begin
                valid[lookup_index][upd_way] <= 1'b1;
                dirty[lookup_index][upd_way] <= 1'b0;
            end
            if (clear_dirty) dirty[lookup_index][upd_way] <= 1'b0;
            // a store into a fresh line wins over the fill clear
            if (set_dirty) dirty[lookup_index][upd_way] <= 1'b1;
            if (touch) begin
                lru[lookup_index][upd_way] <= 1'b0;
                lru[lookup_index][!upd_way] <= 1'b1;
            end
        end
    end

    assign way_hit[0] = valid_q[0] && (way_tag0 == lookup_tag);
    assign way_hit[1] = valid_q[1] && (way_tag1 == lookup_tag);
    assign hit = |way_hit;
    assign hit_way = way_hit[1];

    // lru bit set means that way was not used last
    assign victim_way = lru_q[1];
    assign victim_dirty = valid_q[victim_way] && dirty_q[victim_way];
    assign victim_tag = victim_way ? way_tag1 : way_tag0;

    // a line refilled into the wrong way would show up as a double hit
    assert property (@(posedge clk) disable iff (rst) !(way_hit[0] && way_hit[1]))
        else $error("dcache_meta: both ways hit in set %0d", lookup_index);

endmodule

// File: dcache_ctrl.sv
module dcache_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic cpu_req,
    input  logic cpu_we,
    input  logic [dcache_cfg_pkg::ADDR_W-1:0] cpu_addr,
    input  dcache_cfg_pkg::strb_t cpu_wstrb,
    input  dcache_cfg_pkg::word_t cpu_wdata,
    output logic cpu_ready,
    output dcache_cfg_pkg::word_t cpu_rdata,
    input  logic hit,
    input  logic hit_way,
    input  logic victim_way,
    input  logic victim_dirty,
    input  dcache_cfg_pkg::tag_t victim_tag,
    input  dcache_cfg_pkg::word_t way_data0,
    input  dcache_cfg_pkg::word_t way_data1,
    output dcache_cfg_pkg::index_t lookup_index,
    output dcache_cfg_pkg::tag_t lookup_tag,
    output logic touch,
    output logic set_dirty,
    output logic fill,
    output logic clear_dirty,
    output logic upd_way,
    output logic [dcache_cfg_pkg::NR_WAYS-1:0] tag_we,
    output logic [dcache_cfg_pkg::NR_WAYS-1:0] data_we,
    output dcache_cfg_pkg::strb_t data_wbe,
    output dcache_cfg_pkg::ram_addr_t data_waddr,
    output dcache_cfg_pkg::ram_addr_t data_raddr,
    output dcache_cfg_pkg::word_t data_wdata,
    output logic rd_start,
    output logic [dcache_cfg_pkg::ADDR_W-1:0] rd_addr,
    input  logic fill_valid,
    input  dcache_cfg_pkg::word_t fill_word,
    input  dcache_cfg_pkg::word_idx_t fill_idx,
    input  logic rd_done,
    output logic wb_word_valid,
    output dcache_cfg_pkg::word_t wb_word,
    output logic wb_start,
    output logic [dcache_cfg_pkg::ADDR_W-1:0] wb_addr,
    input  logic wb_done
);
    import dcache_cfg_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_LOOKUP, S_VREAD, S_WB, S_REFILL, S_RESPOND
    } state_t;

    state_t state;
    logic [WORD_IDX_W:0] vcnt;
    logic req_we;
    tag_t req_tag;
    index_t req_index;
    word_idx_t req_word;
    strb_t req_strb;
    word_t req_wdata;
    logic vway;
    tag_t vtag;
    word_t rdata_q;
    word_t strb_mask;
    word_t fill_merged;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            strb_mask[8*b +: 8] = {8{req_strb[b]}};
        end
    end

    // pending store bytes go over the refilled word
    assign fill_merged = (req_we && fill_idx == req_word) ?
        ((fill_word & ~strb_mask) | (req_wdata & strb_mask)) : fill_word;

    assign lookup_index = (state == S_IDLE) ? cpu_addr[OFFSET_W +: INDEX_W] : req_index;
    assign lookup_tag = req_tag;

    assign upd_way = (state == S_LOOKUP) ? hit_way : vway;
    assign touch = ((state == S_LOOKUP) && hit) || ((state == S_REFILL) && rd_done);
    assign set_dirty = touch && req_we;
    assign fill = (state == S_REFILL) && rd_done;
    assign clear_dirty = (state == S_WB) && wb_done;

    always_comb begin
        tag_we = '0;
        tag_we[vway] = fill;
        data_we = '0;
        data_wbe = '1;
        data_waddr = {req_index, fill_idx};
        data_wdata = fill_merged;
        if (state == S_LOOKUP) begin
            data_we[hit_way] = hit && req_we;
            data_wbe = req_strb;
            data_waddr = {req_index, req_word};
            data_wdata = req_wdata;
        end else if (state == S_REFILL) begin
            data_we[vway] = fill_valid;
        end
    end

    assign data_raddr = (state == S_IDLE) ? cpu_addr[OFFSET_W+INDEX_W-1:OFFSET_W-WORD_IDX_W]
                      : {req_index, (state == S_VREAD) ? vcnt[WORD_IDX_W-1:0] : req_word};

    assign rd_start = ((state == S_LOOKUP) && !hit && !victim_dirty) || clear_dirty;
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

    // ram read lags the counter by one cycle
    assign wb_word_valid = (state == S_VREAD) && (vcnt != 0);
    assign wb_word = vway ? way_data1 : way_data0;
    assign wb_start = (state == S_VREAD) && (vcnt == WORDS_PER_LINE);
    assign wb_addr = {vtag, req_index, {OFFSET_W{1'b0}}};

    assign cpu_ready = (state == S_RESPOND);
    assign cpu_rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            vcnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cpu_req) state <= S_LOOKUP;
                end
                S_LOOKUP: begin
                    vcnt <= '0;
                    if (hit) state <= S_RESPOND;
                    else if (victim_dirty) state <= S_VREAD;
                    else state <= S_REFILL;
                end
                S_VREAD: begin
                    vcnt <= vcnt + 1'b1;
                    if (wb_start) state <= S_WB;
                end
                S_WB: begin
                    if (wb_done) state <= S_REFILL;
                end
                S_REFILL: begin
                    if (rd_done) state <= S_RESPOND;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && cpu_req) begin
            req_we <= cpu_we;
            req_tag <= cpu_addr[ADDR_W-1 -: TAG_W];
            req_index <= cpu_addr[OFFSET_W +: INDEX_W];
            req_word <= cpu_addr[OFFSET_W-1 -: WORD_IDX_W];
            req_strb <= cpu_wstrb;
            req_wdata <= cpu_wdata;
        end
        if (state == S_LOOKUP) begin
            vway <= victim_way;
            vtag <= victim_tag;
            rdata_q <= hit_way ? way_data1 : way_data0;
        end
        if (state == S_REFILL && fill_valid && fill_idx == req_word) begin
            rdata_q <= fill_merged;
        end
    end

    assert property (@(posedge clk) disable iff (rst) cpu_ready |=> !cpu_ready)
        else $error("dcache_ctrl: cpu_ready held longer than one cycle");

endmodule

// File: axi_line_master.sv
module axi_line_master (
    input  logic clk,
    input  logic rst,
    input  logic rd_start,
    input  logic [dcache_cfg_pkg::ADDR_W-1:0] rd_addr,
    output logic fill_valid,
    output dcache_cfg_pkg::word_t fill_word,
    output dcache_cfg_pkg::word_idx_t fill_idx,
    output logic rd_done,
    input  logic wb_word_valid,
    input  dcache_cfg_pkg::word_t wb_word,
    input  logic wb_start,
    input  logic [dcache_cfg_pkg::ADDR_W-1:0] wb_addr,
    output logic wb_done,
    output logic [dcache_cfg_pkg::ADDR_W-1:0] ar_addr,
    output axi_cfg_pkg::axi_len_t ar_len,
    output axi_cfg_pkg::axi_size_t ar_size,
    output logic ar_valid,
    input  logic ar_ready,
    input  dcache_cfg_pkg::word_t r_data,
    input  logic r_last,
    input  logic r_valid,
    output logic r_ready,
    output logic [dcache_cfg_pkg::ADDR_W-1:0] aw_addr,
    output axi_cfg_pkg::axi_len_t aw_len,
    output axi_cfg_pkg::axi_size_t aw_size,
    output logic aw_valid,
    input  logic aw_ready,
    output dcache_cfg_pkg::word_t w_data,
    output dcache_cfg_pkg::strb_t w_strb,
    output logic w_last,
    output logic w_valid,
    input  logic w_ready,
    input  logic b_valid,
    output logic b_ready
);
    import dcache_cfg_pkg::*;
    import axi_cfg_pkg::*;

    word_t line_buf [WORDS_PER_LINE];
    word_idx_t buf_ptr;
    word_idx_t r_beat;
    word_idx_t w_beat;

    assign ar_len = AXI_LEN_LINE;
    assign ar_size = AXI_SIZE_WORD;
    assign aw_len = AXI_LEN_LINE;
    assign aw_size = AXI_SIZE_WORD;
    assign w_strb = '1;
    assign b_ready = 1'b1;

    assign fill_valid = r_valid && r_ready;
    assign fill_word = r_data;
    assign fill_idx = r_beat;
    assign w_data = line_buf[w_beat];
    assign w_last = (w_beat == word_idx_t'(WORDS_PER_LINE - 1));
    assign wb_done = b_valid && b_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_valid <= 1'b0;
            r_ready <= 1'b0;
            r_beat <= '0;
            rd_done <= 1'b0;
            aw_valid <= 1'b0;
            w_valid <= 1'b0;
            w_beat <= '0;
            buf_ptr <= '0;
        end else begin
            rd_done <= fill_valid && r_last;
            if (rd_start) begin
                ar_valid <= 1'b1;
                r_beat <= '0;
            end else if (ar_valid && ar_ready) begin
                ar_valid <= 1'b0;
                r_ready <= 1'b1;
            end
            if (fill_valid) begin
                r_beat <= r_beat + 1'b1;
                if (r_last) r_ready <= 1'b0;
            end

            if (wb_word_valid) buf_ptr <= buf_ptr + 1'b1;
            // data follows the address handshake
            if (wb_start) begin
                aw_valid <= 1'b1;
                w_beat <= '0;
            end else if (aw_valid && aw_ready) begin
                aw_valid <= 1'b0;
                w_valid <= 1'b1;
            end
            if (w_valid && w_ready) begin
                w_beat <= w_beat + 1'b1;
                if (w_last) w_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) ar_addr <= rd_addr;
        if (wb_start) aw_addr <= wb_addr;
        if (wb_word_valid) line_buf[buf_ptr] <= wb_word;
    end

    assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("axi_line_master: read address dropped before ar_ready");

    assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("axi_line_master: write address dropped before aw_ready");

endmodule

// File: dcache_top.sv
module dcache_top (
    input  logic clk,
    input  logic rst,
    input  logic cpu_req,
    input  logic cpu_we,
    input  logic [dcache_cfg_pkg::ADDR_W-1:0] cpu_addr,
    input  dcache_cfg_pkg::strb_t cpu_wstrb,
    input  dcache_cfg_pkg::word_t cpu_wdata,
    output logic cpu_ready,
    output dcache_cfg_pkg::word_t cpu_rdata,
    output logic [dcache_cfg_pkg::ADDR_W-1:0] ar_addr,
    output axi_cfg_pkg::axi_len_t ar_len,
    output axi_cfg_pkg::axi_size_t ar_size,
    output logic ar_valid,
    input  logic ar_ready,
    input  dcache_cfg_pkg::word_t r_data,
    input  logic r_last,
    input  logic r_valid,
    output logic r_ready,
    output logic [dcache_cfg_pkg::ADDR_W-1:0] aw_addr,
    output axi_cfg_pkg::axi_len_t aw_len,
    output axi_cfg_pkg::axi_size_t aw_size,
    output logic aw_valid,
    input  logic aw_ready,
    output dcache_cfg_pkg::word_t w_data,
    output dcache_cfg_pkg::strb_t w_strb,
    output logic w_last,
    output logic w_valid,
    input  logic w_ready,
    input  logic b_valid,
    output logic b_ready
);
    import dcache_cfg_pkg::*;

    index_t lookup_index;
    tag_t lookup_tag;
    tag_t way_tag [NR_WAYS];
    word_t way_data [NR_WAYS];
    logic [NR_WAYS-1:0] tag_we;
    logic [NR_WAYS-1:0] data_we;
    strb_t data_wbe;
    ram_addr_t data_waddr;
    ram_addr_t data_raddr;
    word_t data_wdata;
    logic hit;
    logic hit_way;
    logic victim_way;
    logic victim_dirty;
    tag_t victim_tag;
    logic touch;
    logic set_dirty;
    logic fill;
    logic clear_dirty;
    logic upd_way;
    logic rd_start;
    logic rd_done;
    logic [ADDR_W-1:0] rd_addr;
    logic fill_valid;
    word_t fill_word;
    word_idx_t fill_idx;
    logic wb_word_valid;
    word_t wb_word;
    logic wb_start;
    logic [ADDR_W-1:0] wb_addr;
    logic wb_done;

    for (genvar w = 0; w < NR_WAYS; w++) begin : g_way
        dcache_ram #(.entry_t(tag_t), .DEPTH(SETS)) i_tag_ram (
            .clk(clk),
            .we(tag_we[w]),
            .waddr(lookup_index),
            .raddr(lookup_index),
            .wdata(lookup_tag),
            .wbe(1'b1),
            .rdata(way_tag[w])
        );

        dcache_ram #(.entry_t(word_t), .DEPTH(SETS * WORDS_PER_LINE)) i_data_ram (
            .clk(clk),
            .we(data_we[w]),
            .waddr(data_waddr),
            .raddr(data_raddr),
            .wdata(data_wdata),
            .wbe(data_wbe),
            .rdata(way_data[w])
        );
    end

    dcache_meta i_meta (
        .*,
        .way_tag0(way_tag[0]),
        .way_tag1(way_tag[1])
    );

    dcache_ctrl i_ctrl (
        .*,
        .way_data0(way_data[0]),
        .way_data1(way_data[1])
    );

    axi_line_master i_axi_master (.*);

endmodule

// File: tb_axi_mem.sv
module tb_axi_mem #(
    parameter logic [31:0] MEM_BASE = 32'h0001_0000,
    parameter logic [31:0] FILL_XOR = 32'h0000_0000
) (
    input  logic clk,
    input  logic rst,
    input  logic [31:0] ar_addr,
    input  logic ar_valid,
    output logic ar_ready,
    output logic [31:0] r_data,
    output logic r_last,
    output logic r_valid,
    input  logic r_ready,
    input  logic [31:0] aw_addr,
    input  logic aw_valid,
    output logic aw_ready,
    input  logic [31:0] w_data,
    input  logic [3:0] w_strb,
    input  logic w_last,
    input  logic w_valid,
    output logic w_ready,
    output logic b_valid,
    input  logic b_ready,
    output int rd_count,
    output int wr_count,
    output logic wr_busy,
    output logic [31:0] wr_addr,
    output logic [2:0] w_beat
);

    // 4 KB window, word index is address bits 11:2
    logic [31:0] mem [1024];
    logic rd_active;
    logic [31:0] rd_addr;
    logic [1:0] rd_beat;
    logic w_done;

    function automatic logic chance(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (MEM_BASE + 32'(i * 4)) ^ FILL_XOR;
        end
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_last = 1'b0;
        r_data = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        rd_count = 0;
        wr_count = 0;
    end

    always @(posedge clk) begin : step
        logic rst_s;
        logic ar_hs;
        logic r_hs;
        logic aw_hs;
        logic w_hs;
        logic b_hs;
        logic w_last_s;
        logic [31:0] ar_addr_s;
        logic [31:0] aw_addr_s;
        logic [31:0] w_data_s;
        logic [3:0] w_strb_s;

        // handshakes as seen at the edge
        rst_s = rst;
        ar_hs = ar_valid && ar_ready;
        r_hs = r_valid && r_ready;
        aw_hs = aw_valid && aw_ready;
        w_hs = w_valid && w_ready;
        b_hs = b_valid && b_ready;
        w_last_s = w_last;
        ar_addr_s = ar_addr;
        aw_addr_s = aw_addr;
        w_data_s = w_data;
        w_strb_s = w_strb;
        #1;
        if (rst_s) begin
            ar_ready = 1'b0;
            r_valid = 1'b0;
            r_last = 1'b0;
            aw_ready = 1'b0;
            w_ready = 1'b0;
            b_valid = 1'b0;
            rd_active = 1'b0;
            rd_beat = '0;
            wr_busy = 1'b0;
            wr_addr = '0;
            w_beat = '0;
            w_done = 1'b0;
        end else begin
            if (ar_hs) begin
                rd_active = 1'b1;
                rd_addr = ar_addr_s;
                rd_beat = '0;
                rd_count++;
            end
            if (r_hs) begin
                if (r_last) rd_active = 1'b0;
                rd_beat = rd_beat + 1'b1;
            end
            ar_ready = !rd_active && chance(50);
            // a raised r_valid waits for r_ready
            if (!(r_valid && !r_hs)) begin
                r_valid = rd_active && chance(70);
                r_data = mem[{rd_addr[11:4], rd_beat}];
                r_last = (rd_beat == 2'd3);
            end

            if (aw_hs) begin
                wr_busy = 1'b1;
                wr_addr = aw_addr_s;
                w_beat = '0;
                wr_count++;
            end
            if (w_hs) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_strb_s[b]) mem[{wr_addr[11:4], w_beat[1:0]}][8*b +: 8] = w_data_s[8*b +: 8];
                end
                w_beat = w_beat + 1'b1;
                if (w_last_s) w_done = 1'b1;
            end
            if (b_hs) begin
                b_valid = 1'b0;
                wr_busy = 1'b0;
                w_done = 1'b0;
            end
            aw_ready = !wr_busy && chance(50);
            w_ready = wr_busy && !w_done && chance(60);
            if (w_done && !b_valid && chance(50)) b_valid = 1'b1;
        end
    end

endmodule

// File: tb_dcache.sv
module tb_dcache;
    import dcache_cfg_pkg::*;

    localparam logic [31:0] MEM_BASE = 32'h0001_0000;
    localparam logic [31:0] FILL_XOR = 32'h5a3c_96e1;
    localparam int N_REQ = 312;
    localparam int CYCLE_LIMIT = 200 * N_REQ;
    localparam int K_ANY = 0;
    localparam int K_HIT = 1;
    localparam int K_MISS = 2;
    localparam int K_EVICT = 3;

    logic clk;
    logic rst;
    logic cpu_req;
    logic cpu_we;
    logic [31:0] cpu_addr;
    strb_t cpu_wstrb;
    word_t cpu_wdata;
    logic cpu_ready;
    word_t cpu_rdata;
    logic [31:0] ar_addr;
    logic [7:0] ar_len;
    logic [2:0] ar_size;
    logic ar_valid;
    logic ar_ready;
    word_t r_data;
    logic r_last;
    logic r_valid;
    logic r_ready;
    logic [31:0] aw_addr;
    logic [7:0] aw_len;
    logic [2:0] aw_size;
    logic aw_valid;
    logic aw_ready;
    word_t w_data;
    strb_t w_strb;
    logic w_last;
    logic w_valid;
    logic w_ready;
    logic b_valid;
    logic b_ready;
    int rd_count;
    int wr_count;
    logic wr_busy;
    logic [31:0] wr_addr;
    logic [2:0] w_beat;

    word_t shadow [1024];
    logic cur_we = 1'b0;
    word_t exp_rdata = '0;
    int chk_kind = K_ANY;
    int rd_base = 0;
    int wr_base = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int req_count = 0;
    int cycles = 0;

    dcache_top i_dcache_top (.*);

    tb_axi_mem #(.MEM_BASE(MEM_BASE), .FILL_XOR(FILL_XOR)) i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: %0d cycles passed with %0d requests done", cycles, req_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    assert property (@(posedge clk) $fell(rst) |->
        !cpu_ready && !ar_valid && !aw_valid && !w_valid && !r_ready)
        else begin
            errors++;
            $display("handshake outputs not low after reset at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst) cpu_ready && !cur_we |->
        cpu_rdata == exp_rdata)
        else begin
            errors++;
            $display("Error: %0t cpu_rdata expected %08h actual %08h",
                $time, exp_rdata, $sampled(cpu_rdata));
        end

    assert property (@(posedge clk) disable iff (rst) $rose(cpu_req) && chk_kind == K_HIT |->
        ##1 (!cpu_ready && !ar_valid) ##1 (cpu_ready && !ar_valid))
        else begin
            errors++;
            $display("hit at %0t did not respond 2 cycles after the request", $time);
        end

    assert property (@(posedge clk) disable iff (rst) $rose(cpu_req) && chk_kind == K_MISS |->
        ##2 ar_valid)
        else begin
            errors++;
            $display("clean miss at %0t did not raise ar_valid 2 cycles later", $time);
        end

    assert property (@(posedge clk) disable iff (rst) cpu_ready && chk_kind == K_MISS |->
        rd_count == rd_base + 1 && wr_count == wr_base)
        else begin
            errors++;
            $display("clean miss at %0t did not make exactly one read burst", $time);
        end

    assert property (@(posedge clk) disable iff (rst) cpu_ready && chk_kind == K_EVICT |->
        rd_count == rd_base + 1 && wr_count == wr_base + 1)
        else begin
            errors++;
            $display("dirty eviction at %0t did not make one write and one read burst", $time);
        end

    // line-aligned 4-beat word bursts inside the memory window
    assert property (@(posedge clk) disable iff (rst) ar_valid |->
        ar_len == 8'd3 && ar_size == 3'd2 && ar_addr[3:0] == 4'h0 &&
        ar_addr[31:12] == MEM_BASE[31:12])
        else begin
            errors++;
            $display("bad read burst at %0t, address %08h", $time, $sampled(ar_addr));
        end

    assert property (@(posedge clk) disable iff (rst) aw_valid |->
        aw_len == 8'd3 && aw_size == 3'd2 && aw_addr[3:0] == 4'h0 &&
        aw_addr[31:12] == MEM_BASE[31:12])
        else begin
            errors++;
            $display("bad write burst at %0t, address %08h", $time, $sampled(aw_addr));
        end

    assert property (@(posedge clk) disable iff (rst) w_valid && w_ready |->
        w_data == shadow[{wr_addr[11:4], w_beat[1:0]}])
        else begin
            errors++;
            $display("Error: %0t w_data expected %08h actual %08h", $time,
                shadow[{wr_addr[11:4], w_beat[1:0]}], $sampled(w_data));
        end

    assert property (@(posedge clk) disable iff (rst) w_valid && w_ready |->
        w_strb == 4'hf && w_last == (w_beat == 3'd3))
        else begin
            errors++;
            $display("write beat %0d at %0t has wrong strobes or w_last", w_beat, $time);
        end

    assert property (@(posedge clk) disable iff (rst) b_ready)
        else begin
            errors++;
            $display("b_ready was low at %0t", $time);
        end

    // write-back finishes before the refill read starts
    assert property (@(posedge clk) disable iff (rst) ar_valid |-> !aw_valid && !wr_busy)
        else begin
            errors++;
            $display("read burst issued at %0t while a write-back was open", $time);
        end

    assert property (@(posedge clk) disable iff (rst) ar_valid && !ar_ready |=>
        ar_valid && $stable(ar_addr))
        else begin
            errors++;
            $display("ar channel changed before ar_ready at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst) aw_valid && !aw_ready |=>
        aw_valid && $stable(aw_addr))
        else begin
            errors++;
            $display("aw channel changed before aw_ready at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst) w_valid && !w_ready |=>
        w_valid && $stable(w_data) && $stable(w_last))
        else begin
            errors++;
            $display("w channel changed before w_ready at %0t", $time);
        end

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return MEM_BASE + 32'(tag * 512) + 32'(set * 16) + 32'(word * 4);
    endfunction

    task automatic access(input logic we, input logic [31:0] addr, input strb_t strb,
                          input word_t data, input int kind);
        int idx;
        idx = int'(addr[11:2]);
        exp_rdata = shadow[idx];
        cur_we = we;
        chk_kind = kind;
        rd_base = rd_count;
        wr_base = wr_count;
        cpu_req = 1'b1;
        cpu_we = we;
        cpu_addr = addr;
        cpu_wstrb = strb;
        cpu_wdata = data;
        // cpu_ready comes from the state register, settled one unit past the edge
        @(posedge clk);
        #1;
        while (!cpu_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        cpu_req = 1'b0;
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
        req_count++;
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-24s ok", name);
        end else begin
            tests_failed++;
            $display("test %-24s failed, %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int e0;
        void'($urandom(53763));
        rst = 1'b1;
        cpu_req = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = MEM_BASE;
        cpu_wstrb = '0;
        cpu_wdata = '0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = (MEM_BASE + 32'(i * 4)) ^ FILL_XOR;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        e0 = errors;
        access(1'b0, make_addr(0, 0, 1), 4'h0, '0, K_MISS);
        report_test("first load miss", e0);

        e0 = errors;
        access(1'b0, make_addr(0, 0, 2), 4'h0, '0, K_HIT);
        access(1'b0, make_addr(0, 0, 3), 4'h0, '0, K_HIT);
        report_test("same line hit", e0);

        e0 = errors;
        access(1'b1, make_addr(0, 1, 2), 4'b0101, 32'hdead_beef, K_MISS);
        access(1'b0, make_addr(0, 1, 2), 4'h0, '0, K_HIT);
        access(1'b1, make_addr(0, 1, 2), 4'b0010, 32'h1234_5678, K_HIT);
        access(1'b0, make_addr(0, 1, 2), 4'h0, '0, K_HIT);
        report_test("partial store merge", e0);

        // third tag in set 3 pushes out the dirty first line
        e0 = errors;
        access(1'b0, make_addr(1, 3, 0), 4'h0, '0, K_MISS);
        access(1'b1, make_addr(1, 3, 1), 4'b1100, 32'hcafe_f00d, K_HIT);
        access(1'b0, make_addr(2, 3, 0), 4'h0, '0, K_MISS);
        access(1'b0, make_addr(3, 3, 2), 4'h0, '0, K_EVICT);
        access(1'b0, make_addr(1, 3, 1), 4'h0, '0, K_MISS);
        report_test("dirty eviction", e0);

        e0 = errors;
        for (int n = 0; n < 300; n++) begin
            access(1'(($urandom % 2)), make_addr(int'($urandom % 8), int'($urandom % 8),
                int'($urandom % 4)), strb_t'($urandom), word_t'($urandom), K_ANY);
        end
        report_test("random traffic", e0);

        $display("%0d tests run, %0d failed, %0d errors, %0d requests",
            tests_run, tests_failed, errors, req_count);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dcache_top.f
dcache_cfg_pkg.sv
axi_cfg_pkg.sv
dcache_ram.sv
dcache_meta.sv
dcache_ctrl.sv
axi_line_master.sv
dcache_top.sv
tb_axi_mem.sv
tb_dcache.sv

// File: Makefile
SIM := obj_dir/Vtb_dcache
SRCS := $(shell cat dcache_top.f)

.PHONY: all run clean

all: run

$(SIM): dcache_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f dcache_top.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
